// ==== fetch.f ====
design/fetch_pkg.sv
design/icache.sv
design/fetch_unit.sv
design/fetch_top.sv
testbench/burst_memory.sv
testbench/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch

sources:
  - design/fetch_pkg.sv
  - design/icache.sv
  - design/fetch_unit.sv
  - design/fetch_top.sv
  - target: test
    files:
      - testbench/burst_memory.sv
      - testbench/fetch_tb.sv

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;
	import fetch_pkg::*;

	localparam addr_t RESET_PC        = 32'h3000_0000;
	localparam int    CACHE_SETS_LOG2 = 4;
	localparam int    TOTAL_INSTR     = 129; // all tests, plus the run up to the refill in test 5
	localparam int    CYCLE_LIMIT     = 40 * TOTAL_INSTR;

	logic       clock;
	logic       reset;
	addr_t      araddr;
	logic       arvalid;
	logic       arready;
	beat_len_t  arlen;
	burst_t     arburst;
	word_t      rdata;
	logic [1:0] rresp;
	logic       rlast;
	logic       rvalid;
	logic       rready;
	logic       out_valid;
	logic       out_ready;
	addr_t      out_pc;
	word_t      out_inst;
	logic       redirect_valid;
	addr_t      redirect_addr;

	integer seed;
	int     errors      = 0;
	int     checks      = 0;
	int     transfers   = 0;
	int     handshakes  = 0;
	int     cycle_count = 0;
	int     start_errors;
	int     start_handshakes;
	addr_t  expected_pc = RESET_PC;

	fetch_top #(
		.RESET_PC        (RESET_PC),
		.CACHE_SETS_LOG2 (CACHE_SETS_LOG2)
	) i_fetch_top (.*);

	burst_memory #(.SEED(32'h9116)) i_memory (.*);

	// expected memory contents
	function automatic word_t mem_word(addr_t addr);
		return {addr[24:0], addr[31:25]} ^ 32'h5A5A_0F0F;
	endfunction

	task automatic compare_addr(input string name, input addr_t expected, input addr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_word(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_len(input string name, input beat_len_t expected,
		input beat_len_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_burst(input string name, input burst_t expected, input burst_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
		end
	endtask

	task automatic note_failure(input string what);
		errors++;
		$display("Error at %0t ns: %s", $time, what);
	endtask

	task automatic step();
		@(posedge clock);
		#2;
	endtask

	task automatic run_transfers(input int count, input bit random_ready);
		int     target;
		integer rnd;
		target = transfers + count;
		while (transfers < target) begin
			if (random_ready) begin
				rnd       = $random(seed);
				out_ready = rnd[0];
			end
			step();
		end
		out_ready = 1'b1;
	endtask

	// decode side never accepts in the redirect cycle
	task automatic send_redirect(input addr_t target);
		out_ready      = 1'b0;
		redirect_valid = 1'b1;
		redirect_addr  = target;
		step();
		redirect_valid = 1'b0;
		out_ready      = 1'b1;
	endtask

	task automatic report_test(input int number, input string name);
		$display("test %0d %s: %0d errors", number, name, errors - start_errors);
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// follows the expected pc and checks every decode transfer
	always @(posedge clock) begin
		if (!reset) begin
			// a line request is for the pc still awaited
			if (arvalid && arready) begin
				handshakes++;
				compare_len("arlen", 4'd15, arlen);
				compare_burst("arburst", 2'b01, arburst); // INCR
				compare_addr("araddr", expected_pc & ~32'h3F, araddr);
			end
			if (rvalid)
				compare_bit("rready", 1'b1, rready);
			if (redirect_valid) begin
				expected_pc = redirect_addr;
			end else if (out_valid && out_ready) begin
				compare_addr("out_pc", expected_pc, out_pc);
				compare_word("out_inst", mem_word(expected_pc), out_inst);
				expected_pc = expected_pc + 32'd4;
				transfers++;
			end
		end
	end

	initial begin
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Something failed");
		$finish;
	end

	initial begin
		seed           = 32'h9116;
		reset          = 1'b1;
		out_ready      = 1'b0;
		redirect_valid = 1'b0;
		redirect_addr  = '0;

		start_errors = errors;
		repeat (3) begin
			step();
			if (out_valid !== 1'b0 || arvalid !== 1'b0)
				note_failure("out_valid or arvalid was high during reset");
		end
		reset     = 1'b0;
		out_ready = 1'b1;
		run_transfers(1, 1'b0);
		report_test(1, "reset and first fetch");

		start_errors     = errors;
		start_handshakes = handshakes;
		run_transfers(40, 1'b0);
		if (handshakes - start_handshakes != 2)
			note_failure($sformatf("sequential fetch made %0d line requests instead of 2",
				handshakes - start_handshakes));
		report_test(2, "sequential fetch");

		start_errors     = errors;
		start_handshakes = handshakes;
		send_redirect(RESET_PC);
		run_transfers(20, 1'b0);
		if (handshakes != start_handshakes)
			note_failure("a redirect to a cached line went out on the bus");
		report_test(3, "redirect to cached line");

		start_errors = errors;
		run_transfers(30, 1'b1);
		report_test(4, "random decode stalls");

		start_errors     = errors;
		start_handshakes = handshakes;
		while (handshakes == start_handshakes)
			step();
		repeat (2) step(); // burst is now running
		send_redirect(RESET_PC + 32'h208);
		run_transfers(12, 1'b0);
		report_test(5, "redirect during refill");

		start_errors     = errors;
		start_handshakes = handshakes;
		send_redirect(RESET_PC + 32'h404); // same set as the first line
		run_transfers(8, 1'b0);
		send_redirect(RESET_PC);
		run_transfers(4, 1'b0);
		if (handshakes - start_handshakes != 2)
			note_failure("conflicting lines did not both refill");
		report_test(6, "set conflict");

		$display("tests 6, instructions %0d, checks %0d, errors %0d", transfers, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== testbench/burst_memory.sv ====
`timescale 1ns/10ps

module burst_memory #(
	parameter int SEED = 32'h9116
) (
	input  logic                 clock,
	input  logic                 reset,
	input  fetch_pkg::addr_t     araddr,
	input  logic                 arvalid,
	output logic                 arready,
	input  fetch_pkg::beat_len_t arlen,
	input  fetch_pkg::burst_t    arburst,
	output fetch_pkg::word_t     rdata,
	output logic [1:0]           rresp,
	output logic                 rlast,
	output logic                 rvalid,
	input  logic                 rready
);
	import fetch_pkg::*;

	integer    seed;
	integer    gap;
	integer    beat_idx;
	addr_t     beat_addr;
	beat_len_t burst_len;
	burst_t    burst_kind;

	// rotate left by 7, then flip a fixed pattern
	function automatic word_t word_at(addr_t addr);
		return {addr[24:0], addr[31:25]} ^ 32'h5A5A_0F0F;
	endfunction

	initial begin
		seed    = SEED;
		arready = 1'b0;
		rvalid  = 1'b0;
		rlast   = 1'b0;
		rdata   = '0;
		rresp   = 2'b00; // always OKAY
		do @(posedge clock); while (reset);
		#2;
		forever begin
			arready = 1'b1;
			do @(posedge clock); while (!arvalid);
			beat_addr  = araddr;
			burst_len  = arlen;
			burst_kind = arburst;
			#2 arready = 1'b0;
			for (beat_idx = 0; beat_idx <= burst_len; beat_idx++) begin
				gap = $random(seed) & 3; // 0 to 3 idle cycles
				repeat (gap) begin
					@(posedge clock);
					#2;
				end
				rvalid = 1'b1;
				rdata  = word_at(beat_addr);
				rlast  = (beat_idx == burst_len);
				do @(posedge clock); while (!rready);
				#2;
				rvalid = 1'b0;
				rlast  = 1'b0;
				if (burst_kind == BURST_INCR)
					beat_addr = beat_addr + 32'd4;
			end
		end
	end

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top #(
	parameter fetch_pkg::addr_t RESET_PC        = 32'h3000_0000,
	parameter int               CACHE_SETS_LOG2 = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	output fetch_pkg::addr_t     araddr,
	output logic                 arvalid,
	input  logic                 arready,
	output fetch_pkg::beat_len_t arlen,
	output fetch_pkg::burst_t    arburst,
	input  fetch_pkg::word_t     rdata,
	input  logic [1:0]           rresp,
	input  logic                 rlast,
	input  logic                 rvalid,
	output logic                 rready,
	output logic                 out_valid,
	input  logic                 out_ready,
	output fetch_pkg::addr_t     out_pc,
	output fetch_pkg::word_t     out_inst,
	input  logic                 redirect_valid,
	input  fetch_pkg::addr_t     redirect_addr
);
	import fetch_pkg::*;

	// lookup path
	logic  lookup_valid;
	addr_t lookup_addr;
	logic  hit_valid;
	logic  hit;
	word_t hit_word;

	// refill path
	logic  fill_valid;
	addr_t fill_addr;
	word_t fill_word;
	logic  fill_last;

	fetch_unit #(
		.RESET_PC        (RESET_PC),
		.CACHE_SETS_LOG2 (CACHE_SETS_LOG2)
	) i_fetch_unit (.*);

	icache #(
		.CACHE_SETS_LOG2 (CACHE_SETS_LOG2)
	) i_icache (.*);

endmodule

// ==== design/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit #(
	parameter fetch_pkg::addr_t RESET_PC        = 32'h3000_0000,
	parameter int               CACHE_SETS_LOG2 = 4
) (
	input  logic                 clock,
	input  logic                 reset,
	output fetch_pkg::addr_t     araddr,
	output logic                 arvalid,
	input  logic                 arready,
	output fetch_pkg::beat_len_t arlen,
	output fetch_pkg::burst_t    arburst,
	input  fetch_pkg::word_t     rdata,
	input  logic [1:0]           rresp, // errors not handled
	input  logic                 rlast,
	input  logic                 rvalid,
	output logic                 rready,
	output logic                 out_valid,
	input  logic                 out_ready,
	output fetch_pkg::addr_t     out_pc,
	output fetch_pkg::word_t     out_inst,
	input  logic                 redirect_valid,
	input  fetch_pkg::addr_t     redirect_addr,
	output logic                 lookup_valid,
	output fetch_pkg::addr_t     lookup_addr,
	input  logic                 hit_valid,
	input  logic                 hit,
	input  fetch_pkg::word_t     hit_word,
	output logic                 fill_valid,
	output fetch_pkg::addr_t     fill_addr,
	output fetch_pkg::word_t     fill_word,
	output logic                 fill_last
);
	import fetch_pkg::*;

	localparam int TAG_BITS = 32 - CACHE_SETS_LOG2 - LINE_BYTES_LOG2;

	typedef enum logic [2:0] {
		idle,
		lookup,
		request,
		refill,
		present
	} state_t;

	state_t state;
	addr_t  pc;               // address being fetched or presented
	logic   redirect_pending; // redirect seen while a burst runs

	logic [TAG_BITS-1:0]        refill_tag;
	logic [CACHE_SETS_LOG2-1:0] refill_index;
	line_offset_t               beat_cnt;
	line_offset_t               pc_offset;

	logic transfer;
	logic beat;

	assign transfer  = out_valid & out_ready & ~redirect_valid;
	assign beat      = rvalid & rready;
	assign pc_offset = pc[LINE_BYTES_LOG2-1:2];

	assign rready  = 1'b1;
	assign arlen   = BURST_LEN_LINE;
	assign arburst = BURST_INCR;
	assign araddr  = {refill_tag, refill_index, {LINE_BYTES_LOG2{1'b0}}};

	// next pc is looked up in the same cycle as the transfer
	assign lookup_valid = (state == idle & ~redirect_valid) | (state == present & transfer);
	assign lookup_addr  = (state == present) ? pc + 32'd4 : pc;

	// beats go straight into the cache
	assign fill_valid = (state == refill) & beat;
	assign fill_addr  = {refill_tag, refill_index, beat_cnt, 2'b00};
	assign fill_word  = rdata;
	assign fill_last  = rlast;

	always_ff @(posedge clock) begin
		if (reset) begin
			state            <= idle;
			pc               <= RESET_PC;
			redirect_pending <= 1'b0;
			out_valid        <= 1'b0;
			arvalid          <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (redirect_valid)
						pc <= redirect_addr;
					else
						state <= lookup;
				end
				lookup: begin
					if (redirect_valid) begin
						pc    <= redirect_addr; // result of this lookup is dropped
						state <= idle;
					end else if (hit_valid) begin
						if (hit) begin
							out_valid <= 1'b1;
							state     <= present;
						end else begin
							arvalid <= 1'b1;
							state   <= request;
						end
					end
				end
				request: begin
					if (redirect_valid) begin
						pc               <= redirect_addr;
						redirect_pending <= 1'b1;
					end
					if (arready) begin
						arvalid <= 1'b0;
						state   <= refill;
					end
				end
				refill: begin
					if (redirect_valid)
						pc <= redirect_addr;
					if (beat & rlast) begin
						redirect_pending <= 1'b0;
						if (redirect_pending | redirect_valid) begin
							state <= idle;
						end else begin
							out_valid <= 1'b1;
							state     <= present;
						end
					end else if (redirect_valid) begin
						redirect_pending <= 1'b1; // let the burst finish
					end
				end
				present: begin
					if (redirect_valid) begin
						out_valid <= 1'b0;
						pc        <= redirect_addr;
						state     <= idle;
					end else if (out_ready) begin
						out_valid <= 1'b0;
						pc        <= pc + 32'd4;
						state     <= lookup;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == lookup & hit_valid & ~hit) begin
			refill_tag   <= pc[31 -: TAG_BITS];
			refill_index <= pc[LINE_BYTES_LOG2 +: CACHE_SETS_LOG2];
		end
		if (state == request)
			beat_cnt <= '0;
		else if (fill_valid)
			beat_cnt <= beat_cnt + 1'b1;
	end

	// output payload, only loaded while nothing is presented
	always_ff @(posedge clock) begin
		if (state == lookup & hit_valid & hit) begin
			out_pc   <= pc;
			out_inst <= hit_word;
		end
		// missed word taken from the bus as it passes
		if (fill_valid & (beat_cnt == pc_offset) & ~redirect_pending & ~redirect_valid)
			out_inst <= rdata;
		if (fill_valid & rlast)
			out_pc <= pc;
	end

endmodule

// ==== design/icache.sv ====
`timescale 1ns/10ps

module icache #(
	parameter int CACHE_SETS_LOG2 = 4
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             lookup_valid,
	input  fetch_pkg::addr_t lookup_addr,
	input  logic             fill_valid,
	input  fetch_pkg::addr_t fill_addr,
	input  fetch_pkg::word_t fill_word,
	input  logic             fill_last,
	output logic             hit_valid,
	output logic             hit,
	output fetch_pkg::word_t hit_word
);
	import fetch_pkg::*;

	localparam int SETS     = 1 << CACHE_SETS_LOG2;
	localparam int TAG_BITS = 32 - CACHE_SETS_LOG2 - LINE_BYTES_LOG2;

	typedef logic [TAG_BITS-1:0]        tag_t;
	typedef logic [CACHE_SETS_LOG2-1:0] index_t;

	tag_t            tag_mem [SETS];
	word_t           data_mem [SETS * LINE_WORDS];
	logic [SETS-1:0] valid_bits;

	index_t sweep_idx;
	logic   sweeping; // valid bits still being cleared

	tag_t         lookup_tag;
	index_t       lookup_index;
	line_offset_t lookup_offset;
	tag_t         fill_tag;
	index_t       fill_index;
	line_offset_t fill_offset;

	assign lookup_tag    = lookup_addr[31 -: TAG_BITS];
	assign lookup_index  = lookup_addr[LINE_BYTES_LOG2 +: CACHE_SETS_LOG2];
	assign lookup_offset = lookup_addr[LINE_BYTES_LOG2-1:2];

	assign fill_tag    = fill_addr[31 -: TAG_BITS];
	assign fill_index  = fill_addr[LINE_BYTES_LOG2 +: CACHE_SETS_LOG2];
	assign fill_offset = fill_addr[LINE_BYTES_LOG2-1:2];

	// walk all sets once, starting from reset
	always_ff @(posedge clock) begin
		if (reset) begin
			sweeping  <= 1'b1;
			sweep_idx <= '0;
		end else if (sweeping) begin
			sweep_idx <= sweep_idx + 1'b1;
			if (&sweep_idx)
				sweeping <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (sweeping)
			valid_bits[sweep_idx] <= 1'b0;
		if (fill_valid & fill_last)
			valid_bits[fill_index] <= 1'b1; // line complete
	end

	// one word per beat, tag goes in with the last one
	always_ff @(posedge clock) begin
		if (fill_valid) begin
			data_mem[{fill_index, fill_offset}] <= fill_word;
			if (fill_last)
				tag_mem[fill_index] <= fill_tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			hit_valid <= 1'b0;
		end else begin
			hit_valid <= lookup_valid;
		end
	end

	// registered read and tag compare
	always_ff @(posedge clock) begin
		if (lookup_valid) begin
			hit_word <= data_mem[{lookup_index, lookup_offset}];
			hit      <= ~sweeping & valid_bits[lookup_index] &
				(tag_mem[lookup_index] == lookup_tag);
		end
	end

endmodule

// ==== design/fetch_pkg.sv ====
package fetch_pkg;

	typedef logic [31:0] addr_t;     // byte address
	typedef logic [31:0] word_t;     // one instruction
	typedef logic [3:0]  line_offset_t;
	typedef logic [3:0]  beat_len_t; // arlen
	typedef logic [1:0]  burst_t;    // arburst

	// cache line geometry, 16 words of 4 bytes
	localparam int LINE_WORDS      = 16;
	localparam int LINE_BYTES_LOG2 = 6;

	// a whole line comes back as one incrementing burst
	localparam burst_t    BURST_INCR     = 2'b01;
	localparam beat_len_t BURST_LEN_LINE = 4'd15; // 16 beats

endpackage
